//--- logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int XLEN = 32;                       // word and address width
    typedef logic [XLEN-1:0] word_t;

    localparam int BURST_W = 64;                    // one memory beat
    typedef logic [BURST_W-1:0] burst_t;

    localparam int LINE_W         = 256;
    localparam int BEATS_PER_LINE = LINE_W / BURST_W;
    localparam int WORDS_PER_LINE = LINE_W / XLEN;

    localparam int LINE_OFS_W = 5;                  // byte offset inside a line
    localparam int WORD_SEL_W = 3;                  // word index inside a line
    localparam int BEAT_CNT_W = 2;

    typedef logic [XLEN-LINE_OFS_W-1:0] line_tag_t;

    // the burst assembler fills a line by beats, the line buffer reads it by words
    typedef union packed {
        burst_t [BEATS_PER_LINE-1:0] beats;         // beat 0 at lowest address
        word_t  [WORDS_PER_LINE-1:0] words;         // word 0 at lowest address
    } cacheline_t;

endpackage

`default_nettype wire

//--- logic/line_fill_if.sv
`timescale 1ns/1ps
`default_nettype none

interface line_fill_if;

    logic                   fill_req;               // level, held while the pc misses
    fetch_pkg::word_t       fill_addr;              // line aligned
    fetch_pkg::cacheline_t  line_data;
    fetch_pkg::line_tag_t   line_tag;
    logic                   line_valid;             // one cycle pulse

    modport requester (
        output fill_req,
        output fill_addr
    );

    modport filler (
        input  fill_req,
        input  fill_addr,
        output line_data,
        output line_tag,
        output line_valid
    );

    modport sink (
        input  line_data,
        input  line_tag,
        input  line_valid
    );

    modport monitor (
        input  fill_req,
        input  fill_addr,
        input  line_data,
        input  line_tag,
        input  line_valid
    );

endinterface

`default_nettype wire

//--- logic/fetch_push_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_push_if;

    logic               push;                       // ignored while flush is high
    fetch_pkg::word_t   push_inst;
    fetch_pkg::word_t   push_pc;
    logic               flush;
    logic               full;

    modport producer (
        output push,
        output push_inst,
        output push_pc,
        output flush,
        input  full
    );

    modport consumer (
        input  push,
        input  push_inst,
        input  push_pc,
        input  flush,
        output full
    );

endinterface

`default_nettype wire

//--- logic/burst_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module burst_assembler (
    input  wire logic               clk,
    input  wire logic               rst,

    line_fill_if.filler             fill,

    output      fetch_pkg::word_t   bmem_addr_o,
    output      logic               bmem_read_o,
    input  wire logic               bmem_ready_i,
    input  wire fetch_pkg::burst_t  bmem_rdata_i,
    input  wire logic               bmem_rvalid_i
);

    typedef enum logic {
        S_IDLE,
        S_COLLECT
    } state_e;

    state_e                             state_q;
    logic   [fetch_pkg::BEAT_CNT_W-1:0] beat_q;     // next beat slot
    logic                               done_q;     // line complete, drives line_valid
    fetch_pkg::cacheline_t              line_q;
    fetch_pkg::line_tag_t               tag_q;

    logic   issue;
    logic   beat_en;
    logic   last_beat;

    // read only from idle, and only when memory can take it
    assign issue     = (state_q == S_IDLE) && fill.fill_req && bmem_ready_i;
    assign beat_en   = (state_q == S_COLLECT) && !done_q && bmem_rvalid_i;
    assign last_beat = (beat_q == fetch_pkg::BEAT_CNT_W'(fetch_pkg::BEATS_PER_LINE - 1));

    assign bmem_read_o = issue;
    assign bmem_addr_o = fill.fill_addr;            // already line aligned

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            beat_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (issue) begin
                        state_q <= S_COLLECT;
                    end
                end
                S_COLLECT: begin
                    if (done_q) begin
                        state_q <= S_IDLE;          // line handed over last cycle
                    end else if (beat_en) begin
                        beat_q <= beat_q + 1'b1;    // wraps to 0 after the last beat
                        done_q <= last_beat;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            tag_q <= fill.fill_addr[fetch_pkg::XLEN-1:fetch_pkg::LINE_OFS_W];
        end
        if (beat_en) begin
            line_q.beats[beat_q] <= bmem_rdata_i;   // beats arrive lowest address first
        end
    end

    assign fill.line_data  = line_q;
    assign fill.line_tag   = tag_q;                 // tag of the line requested, not the current pc
    assign fill.line_valid = done_q;

endmodule

`default_nettype wire

//--- logic/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  wire logic               clk,
    input  wire logic               rst,

    line_fill_if.sink               fill,

    input  wire fetch_pkg::word_t   pc_i,
    output      logic               hit_o,
    output      fetch_pkg::word_t   word_o
);

    logic                   valid_q;
    fetch_pkg::line_tag_t   tag_q;
    fetch_pkg::cacheline_t  line_q;

    fetch_pkg::line_tag_t               pc_tag;
    logic [fetch_pkg::WORD_SEL_W-1:0]   word_sel;

    assign pc_tag   = pc_i[fetch_pkg::XLEN-1:fetch_pkg::LINE_OFS_W];
    assign word_sel = pc_i[fetch_pkg::LINE_OFS_W-1 -: fetch_pkg::WORD_SEL_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (fill.line_valid) begin
            valid_q <= 1'b1;
        end
    end

    // a new line simply replaces the old one
    always_ff @(posedge clk) begin
        if (fill.line_valid) begin
            tag_q  <= fill.line_tag;
            line_q <= fill.line_data;
        end
    end

    assign hit_o  = valid_q && (tag_q == pc_tag);
    assign word_o = line_q.words[word_sel];         // word view of the same line

endmodule

`default_nettype wire

//--- logic/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl #(
    parameter fetch_pkg::word_t RESET_PC = 32'h1eceb000
) (
    input  wire logic               clk,
    input  wire logic               rst,

    line_fill_if.requester          fill,
    fetch_push_if.producer          push,

    input  wire logic               hit_i,
    input  wire fetch_pkg::word_t   word_i,
    output      fetch_pkg::word_t   pc_o,

    input  wire logic               redirect_i,
    input  wire fetch_pkg::word_t   redirect_addr_i
);

    fetch_pkg::word_t   pc_q;
    fetch_pkg::word_t   pc_next;
    logic               fetch_en_q;                 // low through reset and one cycle after
    logic               do_push;

    // a hit only turns into a push when the queue has room and no redirect is pending
    assign do_push = hit_i && !push.full && !redirect_i;

    always_comb begin
        if (redirect_i) begin
            pc_next = redirect_addr_i;              // redirect wins
        end else if (do_push) begin
            pc_next = pc_q + fetch_pkg::XLEN'(4);
        end else begin
            pc_next = pc_q;                         // miss or back-pressure
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q       <= RESET_PC;
            fetch_en_q <= 1'b0;
        end else begin
            pc_q       <= pc_next;
            fetch_en_q <= 1'b1;
        end
    end

    assign pc_o = pc_q;

    // miss request to the burst assembler
    assign fill.fill_req  = fetch_en_q && !hit_i;
    assign fill.fill_addr = {pc_q[fetch_pkg::XLEN-1:fetch_pkg::LINE_OFS_W],
                             {fetch_pkg::LINE_OFS_W{1'b0}}};

    // queue side
    assign push.push      = do_push;
    assign push.push_inst = word_i;
    assign push.push_pc   = pc_q;
    assign push.flush     = redirect_i;             // drop everything fetched on the old path

endmodule

`default_nettype wire

//--- logic/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  wire logic               clk,
    input  wire logic               rst,

    fetch_push_if.consumer          push,

    input  wire logic               dequeue_i,
    output      fetch_pkg::word_t   inst_o,
    output      fetch_pkg::word_t   pc_o,
    output      logic               valid_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    fetch_pkg::word_t   inst_mem [QUEUE_DEPTH];
    fetch_pkg::word_t   pc_mem   [QUEUE_DEPTH];

    logic [PTR_W-1:0]   head_q;
    logic [PTR_W-1:0]   tail_q;
    logic [PTR_W:0]     count_q;

    logic   full;
    logic   do_push;
    logic   do_pop;

    assign full    = (count_q == (PTR_W + 1)'(QUEUE_DEPTH));
    assign valid_o = (count_q != '0);

    assign do_push = push.push && !push.flush && !full;
    assign do_pop  = dequeue_i && valid_o && !push.flush;

    always_ff @(posedge clk) begin
        if (rst || push.flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                tail_q <= tail_q + 1'b1;            // wraps, depth is a power of two
            end
            if (do_pop) begin
                head_q <= head_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            inst_mem[tail_q] <= push.push_inst;
            pc_mem[tail_q]   <= push.push_pc;
        end
    end

    // head is visible the cycle after its push
    assign inst_o = inst_mem[head_q];
    assign pc_o   = pc_mem[head_q];

    assign push.full = full;

endmodule

`default_nettype wire

//--- logic/fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend #(
    parameter fetch_pkg::word_t RESET_PC    = 32'h1eceb000,
    parameter int               QUEUE_DEPTH = 16
) (
    input  wire logic               clk,
    input  wire logic               rst,

    // burst memory
    output      fetch_pkg::word_t   bmem_addr_o,
    output      logic               bmem_read_o,
    input  wire logic               bmem_ready_i,
    input  wire fetch_pkg::burst_t  bmem_rdata_i,
    input  wire logic               bmem_rvalid_i,

    // branch resolution
    input  wire logic               redirect_i,
    input  wire fetch_pkg::word_t   redirect_addr_i,

    // downstream consumer
    output      fetch_pkg::word_t   inst_o,
    output      fetch_pkg::word_t   inst_pc_o,
    output      logic               inst_valid_o,
    input  wire logic               dequeue_i
);

    line_fill_if    fill_bus ();
    fetch_push_if   push_bus ();

    fetch_pkg::word_t   pc;
    fetch_pkg::word_t   fetch_word;
    logic               hit;

    burst_assembler burst_assembler_i (
        .clk            (clk),
        .rst            (rst),
        .fill           (fill_bus.filler),
        .bmem_addr_o    (bmem_addr_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_ready_i   (bmem_ready_i),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_rvalid_i  (bmem_rvalid_i)
    );

    line_buffer line_buffer_i (
        .clk            (clk),
        .rst            (rst),
        .fill           (fill_bus.sink),
        .pc_i           (pc),
        .hit_o          (hit),
        .word_o         (fetch_word)
    );

    fetch_ctrl #(
        .RESET_PC       (RESET_PC)
    ) fetch_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .fill           (fill_bus.requester),
        .push           (push_bus.producer),
        .hit_i          (hit),
        .word_i         (fetch_word),
        .pc_o           (pc),
        .redirect_i     (redirect_i),
        .redirect_addr_i(redirect_addr_i)
    );

    fetch_queue #(
        .QUEUE_DEPTH    (QUEUE_DEPTH)
    ) fetch_queue_i (
        .clk            (clk),
        .rst            (rst),
        .push           (push_bus.consumer),
        .dequeue_i      (dequeue_i),
        .inst_o         (inst_o),
        .pc_o           (inst_pc_o),
        .valid_o        (inst_valid_o)
    );

endmodule

`default_nettype wire

//--- bench/fetch_frontend_sva.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_sva (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire fetch_pkg::word_t   bmem_addr_o,
    input  wire logic               bmem_read_o,
    input  wire logic               bmem_ready_i,
    input  wire logic               bmem_rvalid_i,
    input  wire logic               redirect_i,
    input  wire logic               inst_valid_o
);

    logic [2:0] beats_left_q;                       // beats still owed on the open read

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_left_q <= '0;
        end else if (bmem_read_o) begin
            beats_left_q <= 3'(fetch_pkg::BEATS_PER_LINE);
        end else if (bmem_rvalid_i && beats_left_q != '0) begin
            beats_left_q <= beats_left_q - 3'd1;
        end
    end

    read_needs_ready: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> bmem_ready_i)
        else $error("bmem_read_o issued while bmem_ready_i low");

    read_line_aligned: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> (bmem_addr_o[fetch_pkg::LINE_OFS_W-1:0] == '0))
        else $error("bmem_addr_o not line aligned on a read");

    one_fill_open: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> (beats_left_q == '0))
        else $error("second read before the fourth beat of the previous one");

    // the first sampled edge is still before reset takes hold
    quiet_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!bmem_read_o && !inst_valid_o))
        else $error("bmem_read_o or inst_valid_o high during reset");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (!bmem_read_o && !inst_valid_o))
        else $error("bmem_read_o or inst_valid_o high in the cycle after reset");

    redirect_empties_queue: assert property (@(posedge clk) disable iff (rst)
        redirect_i |=> !inst_valid_o)
        else $error("inst_valid_o high in the cycle after a redirect");

endmodule

`default_nettype wire

//--- bench/tb_fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;

    localparam logic [31:0] RESET_PC     = 32'h1eceb000;
    localparam int          QUEUE_DEPTH  = 16;
    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 4;
    localparam int          SEED         = 63491;

    localparam int SEQ_WORDS = 200;
    localparam int BP_WORDS  = 200;
    localparam int RDR_WORDS = 400;
    localparam int LAT_BOUND = 40;                  // cycles per word incl. misses and stalls
    localparam int WATCHDOG_CYCLES = (SEQ_WORDS + BP_WORDS + RDR_WORDS) * LAT_BOUND + 100;

    logic           clk;
    logic           rst;
    logic [31:0]    bmem_addr_o;
    logic           bmem_read_o;
    logic           bmem_ready_i;
    logic [63:0]    bmem_rdata_i;
    logic           bmem_rvalid_i;
    logic           redirect_i;
    logic [31:0]    redirect_addr_i;
    logic [31:0]    inst_o;
    logic [31:0]    inst_pc_o;
    logic           inst_valid_o;
    logic           dequeue_i;

    logic           mem_busy;                       // read accepted, beats not all given
    logic [31:0]    mem_addr;
    int             mem_beat;
    int             mem_delay;

    logic [31:0]    exp_pc;                         // pc of the next word to dequeue
    logic           after_redirect;
    int             deq_pct;
    int             rdr_pct;
    int             words_done;
    int             test_checks;
    int             test_errors;
    int             total_checks;
    int             total_errors;
    int             tests_run;

    fetch_frontend #(
        .RESET_PC       (RESET_PC),
        .QUEUE_DEPTH    (QUEUE_DEPTH)
    ) i_fetch_frontend (
        .clk            (clk),
        .rst            (rst),
        .bmem_addr_o    (bmem_addr_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_ready_i   (bmem_ready_i),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_rvalid_i  (bmem_rvalid_i),
        .redirect_i     (redirect_i),
        .redirect_addr_i(redirect_addr_i),
        .inst_o         (inst_o),
        .inst_pc_o      (inst_pc_o),
        .inst_valid_o   (inst_valid_o),
        .dequeue_i      (dequeue_i)
    );

    bind fetch_frontend fetch_frontend_sva i_fetch_frontend_sva (
        .clk            (clk),
        .rst            (rst),
        .bmem_addr_o    (bmem_addr_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_ready_i   (bmem_ready_i),
        .bmem_rvalid_i  (bmem_rvalid_i),
        .redirect_i     (redirect_i),
        .inst_valid_o   (inst_valid_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // memory content, a fixed mix of the word address
    function automatic logic [31:0] word_hash(input logic [31:0] addr);
        logic [31:0] h;
        h = addr ^ 32'h5bd1e995;
        h = h * 32'h9e3779b1;
        h = h ^ (h >> 15);
        return h;
    endfunction

    function automatic logic [31:0] pick_redirect(input logic [31:0] pc, input logic [31:0] r);
        logic [31:0] target;
        case (r[1:0])
            2'd0:    target = {pc[31:5], r[4:2], 2'b00};            // same line
            2'd1:    target = pc + {22'd0, r[11:4], 2'b00};         // a few lines ahead
            2'd2:    target = pc - {22'd0, r[11:4], 2'b00};
            default: target = {r[31:2], 2'b00};                     // anywhere
        endcase
        return target;
    endfunction

    task automatic report_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        test_errors++;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        test_errors++;
    endtask

    task automatic drive_memory();
        if (mem_busy && mem_beat == fetch_pkg::BEATS_PER_LINE) begin
            mem_busy = 1'b0;                        // last beat was taken at the previous edge
        end
        bmem_ready_i  = ($urandom % 4) != 0;
        bmem_rvalid_i = 1'b0;
        if (mem_busy) begin
            if (mem_delay != 0) begin
                mem_delay--;
            end else if (($urandom % 3) != 0) begin
                bmem_rvalid_i = 1'b1;
                bmem_rdata_i  = {word_hash(mem_addr + 32'(mem_beat * 8) + 32'd4),
                                 word_hash(mem_addr + 32'(mem_beat * 8))};
                mem_beat++;
            end
        end
    endtask

    task automatic drive_consumer();
        redirect_i = 1'b0;
        dequeue_i  = 1'b0;
        if (($urandom % 100) < rdr_pct) begin
            redirect_i      = 1'b1;
            redirect_addr_i = pick_redirect(exp_pc, $urandom);
        end else begin
            dequeue_i = ($urandom % 100) < deq_pct;  // never together with a redirect
        end
    endtask

    task automatic check_bus();
        if (bmem_read_o) begin
            if (!bmem_ready_i) begin
                report_failure("read issued while memory was not ready");
            end
            if (bmem_addr_o[4:0] != 5'd0) begin
                report_failure("read address is not line aligned");
            end
            if (mem_busy) begin
                report_failure("second read issued before the fourth beat arrived");
            end else begin
                mem_busy  = 1'b1;
                mem_addr  = bmem_addr_o;
                mem_beat  = 0;
                mem_delay = $urandom % 8;
            end
        end
    endtask

    task automatic check_consumer();
        if (after_redirect && inst_valid_o) begin
            report_failure("queue still holds words in the cycle after a redirect");
        end
        after_redirect = 1'b0;
        if (redirect_i) begin
            exp_pc         = redirect_addr_i;
            after_redirect = 1'b1;
        end else if (dequeue_i && inst_valid_o) begin
            test_checks++;
            if (inst_o !== word_hash(exp_pc)) begin
                report_mismatch("inst_o", inst_o, word_hash(exp_pc));
            end
            if (inst_pc_o !== exp_pc) begin
                report_mismatch("inst_pc_o", inst_pc_o, exp_pc);
            end
            exp_pc = exp_pc + 32'd4;
            words_done++;
        end
    endtask

    // inputs change at the falling edge, outputs are read 1 ns later and hold to the rise
    task automatic run_cycle();
        @(negedge clk);
        drive_memory();
        drive_consumer();
        #1;
        check_bus();
        check_consumer();
    endtask

    task automatic finish_test(input string name);
        $display("test %-16s %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        tests_run++;
    endtask

    task automatic check_reset();
        test_checks = 0;
        test_errors = 0;
        for (int k = 1; k <= RESET_CYCLES; k++) begin
            @(negedge clk);
            bmem_ready_i = ($urandom % 2) != 0;
            if (k == RESET_CYCLES) begin
                rst = 1'b0;                         // next rising edge is the first one out
            end
            #1;
            test_checks++;
            if (bmem_read_o !== 1'b0) begin
                report_failure("bmem_read_o high during or right after reset");
            end
            if (inst_valid_o !== 1'b0) begin
                report_failure("inst_valid_o high during or right after reset");
            end
        end
        finish_test("reset_state");
    endtask

    task automatic run_test(input string name, input int n_words, input int deq, input int rdr);
        deq_pct     = deq;
        rdr_pct     = rdr;
        test_checks = 0;
        test_errors = 0;
        words_done  = 0;
        while (words_done < n_words) begin
            run_cycle();
        end
        finish_test(name);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped delivering words",
                 WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        clk             = 1'b0;
        rst             = 1'b1;
        bmem_ready_i    = 1'b0;
        bmem_rdata_i    = '0;
        bmem_rvalid_i   = 1'b0;
        redirect_i      = 1'b0;
        redirect_addr_i = '0;
        dequeue_i       = 1'b0;
        mem_busy        = 1'b0;
        mem_addr        = '0;
        mem_beat        = 0;
        mem_delay       = 0;
        exp_pc          = RESET_PC;
        after_redirect  = 1'b0;
        deq_pct         = 0;
        rdr_pct         = 0;
        total_checks    = 0;
        total_errors    = 0;
        tests_run       = 0;

        check_reset();
        run_test("sequential_fetch", SEQ_WORDS, 100, 0);
        run_test("back_pressure", BP_WORDS, 20, 0);
        run_test("redirect", RDR_WORDS, 70, 4);

        $display("tests %0d, checks %0d, errors %0d", tests_run, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
logic/fetch_pkg.sv
logic/line_fill_if.sv
logic/fetch_push_if.sv
logic/burst_assembler.sv
logic/line_buffer.sv
logic/fetch_ctrl.sv
logic/fetch_queue.sv
logic/fetch_frontend.sv
bench/fetch_frontend_sva.sv
bench/tb_fetch_frontend.sv

//--- run.sh
#!/bin/sh
# build the fetch front end testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fetch_frontend -f compile.f \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_fetch_frontend | tee /dev/stderr | grep -q -F '** PASS **' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
